//--- src/gpr_arch_pkg.sv
package gpr_arch_pkg;

    localparam int NUM_REGS = 8;
    localparam int REG_W    = 32;

    typedef logic [2:0] addr_t;

    typedef enum logic [1:0] {
        SZ_BYTE  = 2'd0,
        SZ_WORD  = 2'd1,
        SZ_DWORD = 2'd2
    } size_e;

    typedef logic [15:0] upper_t;
    typedef logic [7:0]  byte_t;

    // bit 2 upper, bit 1 high byte, bit 0 low byte.
    typedef logic [2:0] sec_vec_t;

    typedef struct packed {
        addr_t    idx;
        sec_vec_t secs;
    } sized_sel_t;

    // x86 byte encoding maps addresses 4..7 to the high byte of regs 0..3.
    function automatic sized_sel_t sized_sections(addr_t addr, size_e size);
        sized_sel_t sel;
        sel.idx  = addr;
        sel.secs = '0;
        case (size)
            SZ_DWORD: sel.secs = 3'b111;
            SZ_WORD:  sel.secs = 3'b011;
            SZ_BYTE: begin
                if (addr[2]) begin
                    sel.idx  = {1'b0, addr[1:0]};
                    sel.secs = 3'b010;
                end else begin
                    sel.secs = 3'b001;
                end
            end
            default: sel.secs = '0;
        endcase
        return sel;
    endfunction

endpackage

//--- src/gpr_tag_pkg.sv
package gpr_tag_pkg;

    // producer tag width unless the top overrides it.
    localparam int DEFAULT_TAG_W = 7;

    // section positions inside a sec_vec_t.
    localparam int SEC_L = 0;
    localparam int SEC_H = 1;
    localparam int SEC_U = 2;

endpackage

//--- src/gpr_section.sv
`timescale 1ns/1ps

module gpr_section #(
    parameter type data_t = gpr_arch_pkg::byte_t,
    parameter int  TAG_W  = gpr_tag_pkg::DEFAULT_TAG_W
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             load,
    input  data_t            din,
    input  logic             alloc,
    input  logic [TAG_W-1:0] new_tag,
    input  logic             cdb_valid,
    input  logic [TAG_W-1:0] cdb_tag,
    input  logic             flush,
    output data_t            dout,
    output logic             busy,
    output logic [TAG_W-1:0] tag
);

    logic cdb_hit;

    assign cdb_hit = cdb_valid && (cdb_tag == tag);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout <= '0;
        end else if (load) begin
            dout <= din;
        end
    end

    // flush beats allocate, allocate beats completion.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            tag  <= '0;
        end else if (flush) begin
            busy <= 1'b0;
        end else if (alloc) begin
            busy <= 1'b1;
            tag  <= new_tag;
        end else if (cdb_hit) begin
            busy <= 1'b0;
        end
    end

endmodule

//--- src/reg_write_decode.sv
`timescale 1ns/1ps

module reg_write_decode (
    input  logic                                                     wr_en,
    input  gpr_arch_pkg::addr_t                                      wr_addr,
    input  gpr_arch_pkg::size_e                                      wr_size,
    input  logic [gpr_arch_pkg::REG_W-1:0]                           wr_data,
    input  logic                                                     tag_en,
    input  gpr_arch_pkg::addr_t                                      tag_addr,
    input  gpr_arch_pkg::size_e                                      tag_size,
    output gpr_arch_pkg::sec_vec_t [gpr_arch_pkg::NUM_REGS-1:0]      sec_load,
    output gpr_arch_pkg::sec_vec_t [gpr_arch_pkg::NUM_REGS-1:0]      sec_alloc,
    output gpr_arch_pkg::upper_t                                     upper_in,
    output gpr_arch_pkg::byte_t                                      high_in,
    output gpr_arch_pkg::byte_t                                      low_in
);

    import gpr_arch_pkg::*;

    sized_sel_t wr_sel;
    sized_sel_t tag_sel;
    logic       wr_high_byte;

    // ----------------------------------------
    // section enables
    // ----------------------------------------
    always_comb begin
        wr_sel    = sized_sections(wr_addr, wr_size);
        tag_sel   = sized_sections(tag_addr, tag_size);
        sec_load  = '0;
        sec_alloc = '0;
        if (wr_en) begin
            sec_load[wr_sel.idx] = wr_sel.secs;
        end
        if (tag_en) begin
            sec_alloc[tag_sel.idx] = tag_sel.secs;
        end
    end

    // ----------------------------------------
    // data steering
    // ----------------------------------------
    // byte write to ah/ch/dh/bh carries its value in the low byte.
    assign wr_high_byte = (wr_size == SZ_BYTE) && wr_addr[2];

    assign upper_in = wr_data[REG_W-1:16];
    assign low_in   = wr_data[7:0];
    assign high_in  = wr_high_byte ? wr_data[7:0] : wr_data[15:8];

endmodule

//--- src/gpr_bank.sv
`timescale 1ns/1ps

module gpr_bank #(
    parameter int TAG_W = gpr_tag_pkg::DEFAULT_TAG_W
) (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  gpr_arch_pkg::sec_vec_t [gpr_arch_pkg::NUM_REGS-1:0]   sec_load,
    input  gpr_arch_pkg::sec_vec_t [gpr_arch_pkg::NUM_REGS-1:0]   sec_alloc,
    input  gpr_arch_pkg::upper_t                                  upper_in,
    input  gpr_arch_pkg::byte_t                                   high_in,
    input  gpr_arch_pkg::byte_t                                   low_in,
    input  logic [TAG_W-1:0]                                      new_tag,
    input  logic                                                  cdb_valid,
    input  logic [TAG_W-1:0]                                      cdb_tag,
    input  logic                                                  flush,
    output logic [gpr_arch_pkg::NUM_REGS-1:0][gpr_arch_pkg::REG_W-1:0] regs,
    output gpr_arch_pkg::sec_vec_t [gpr_arch_pkg::NUM_REGS-1:0]   busy,
    output logic [gpr_arch_pkg::NUM_REGS-1:0][TAG_W-1:0]          tags_u,
    output logic [gpr_arch_pkg::NUM_REGS-1:0][TAG_W-1:0]          tags_h,
    output logic [gpr_arch_pkg::NUM_REGS-1:0][TAG_W-1:0]          tags_l
);

    import gpr_arch_pkg::*;
    import gpr_tag_pkg::*;

    for (genvar i = 0; i < NUM_REGS; i++) begin : g_reg
        upper_t upper_q;
        byte_t  high_q;
        byte_t  low_q;
        logic   busy_u;
        logic   busy_h;
        logic   busy_l;

        gpr_section #(.data_t(upper_t), .TAG_W(TAG_W)) u_upper (
            .clk(clk), .rst_n(rst_n), .load(sec_load[i][SEC_U]), .din(upper_in),
            .alloc(sec_alloc[i][SEC_U]), .new_tag(new_tag), .cdb_valid(cdb_valid),
            .cdb_tag(cdb_tag), .flush(flush), .dout(upper_q), .busy(busy_u),
            .tag(tags_u[i])
        );

        gpr_section #(.data_t(byte_t), .TAG_W(TAG_W)) u_high (
            .clk(clk), .rst_n(rst_n), .load(sec_load[i][SEC_H]), .din(high_in),
            .alloc(sec_alloc[i][SEC_H]), .new_tag(new_tag), .cdb_valid(cdb_valid),
            .cdb_tag(cdb_tag), .flush(flush), .dout(high_q), .busy(busy_h),
            .tag(tags_h[i])
        );

        gpr_section #(.data_t(byte_t), .TAG_W(TAG_W)) u_low (
            .clk(clk), .rst_n(rst_n), .load(sec_load[i][SEC_L]), .din(low_in),
            .alloc(sec_alloc[i][SEC_L]), .new_tag(new_tag), .cdb_valid(cdb_valid),
            .cdb_tag(cdb_tag), .flush(flush), .dout(low_q), .busy(busy_l),
            .tag(tags_l[i])
        );

        assign regs[i] = {upper_q, high_q, low_q};
        assign busy[i] = {busy_u, busy_h, busy_l};
    end

endmodule

//--- src/gpr_read_port.sv
`timescale 1ns/1ps

module gpr_read_port #(
    parameter int TAG_W = gpr_tag_pkg::DEFAULT_TAG_W
) (
    input  gpr_arch_pkg::addr_t                                   rd_addr,
    input  gpr_arch_pkg::size_e                                   rd_size,
    input  logic [gpr_arch_pkg::NUM_REGS-1:0][gpr_arch_pkg::REG_W-1:0] regs,
    input  gpr_arch_pkg::sec_vec_t [gpr_arch_pkg::NUM_REGS-1:0]   busy,
    input  logic [gpr_arch_pkg::NUM_REGS-1:0][TAG_W-1:0]          tags_u,
    input  logic [gpr_arch_pkg::NUM_REGS-1:0][TAG_W-1:0]          tags_h,
    input  logic [gpr_arch_pkg::NUM_REGS-1:0][TAG_W-1:0]          tags_l,
    output logic [gpr_arch_pkg::REG_W-1:0]                        rd_data,
    output gpr_arch_pkg::sec_vec_t                                rd_busy,
    output logic [TAG_W-1:0]                                      rd_tag_u,
    output logic [TAG_W-1:0]                                      rd_tag_h,
    output logic [TAG_W-1:0]                                      rd_tag_l
);

    import gpr_arch_pkg::*;
    import gpr_tag_pkg::*;

    sized_sel_t       sel;
    logic [REG_W-1:0] word;

    // ----------------------------------------
    // data select and sign extension
    // ----------------------------------------
    always_comb begin
        sel  = sized_sections(rd_addr, rd_size);
        word = regs[sel.idx];
        case (rd_size)
            SZ_DWORD: rd_data = word;
            SZ_WORD:  rd_data = {{(REG_W-16){word[15]}}, word[15:0]};
            SZ_BYTE: begin
                if (sel.secs[SEC_H]) begin
                    rd_data = {{(REG_W-8){word[15]}}, word[15:8]};
                end else begin
                    rd_data = {{(REG_W-8){word[7]}}, word[7:0]};
                end
            end
            default: rd_data = '0;
        endcase
    end

    // ----------------------------------------
    // pending info, covered sections only
    // ----------------------------------------
    assign rd_busy  = busy[sel.idx] & sel.secs;
    assign rd_tag_u = sel.secs[SEC_U] ? tags_u[sel.idx] : '0;
    assign rd_tag_h = sel.secs[SEC_H] ? tags_h[sel.idx] : '0;
    assign rd_tag_l = sel.secs[SEC_L] ? tags_l[sel.idx] : '0;

endmodule

//--- src/gpr_regfile_top.sv
`timescale 1ns/1ps

module gpr_regfile_top #(
    parameter int TAG_W = gpr_tag_pkg::DEFAULT_TAG_W
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wr_en,
    input  gpr_arch_pkg::addr_t            wr_addr,
    input  gpr_arch_pkg::size_e            wr_size,
    input  logic [gpr_arch_pkg::REG_W-1:0] wr_data,
    input  logic                           tag_en,
    input  gpr_arch_pkg::addr_t            tag_addr,
    input  gpr_arch_pkg::size_e            tag_size,
    input  logic [TAG_W-1:0]               new_tag,
    input  logic                           cdb_valid,
    input  logic [TAG_W-1:0]               cdb_tag,
    input  logic                           flush,
    input  gpr_arch_pkg::addr_t            rd_addr,
    input  gpr_arch_pkg::size_e            rd_size,
    output logic [gpr_arch_pkg::REG_W-1:0] rd_data,
    output gpr_arch_pkg::sec_vec_t         rd_busy,
    output logic [TAG_W-1:0]               rd_tag_u,
    output logic [TAG_W-1:0]               rd_tag_h,
    output logic [TAG_W-1:0]               rd_tag_l
);

    import gpr_arch_pkg::*;

    sec_vec_t [NUM_REGS-1:0]              sec_load;
    sec_vec_t [NUM_REGS-1:0]              sec_alloc;
    upper_t                               upper_in;
    byte_t                                high_in;
    byte_t                                low_in;
    logic     [NUM_REGS-1:0][REG_W-1:0]   regs;
    sec_vec_t [NUM_REGS-1:0]              busy;
    logic     [NUM_REGS-1:0][TAG_W-1:0]   tags_u;
    logic     [NUM_REGS-1:0][TAG_W-1:0]   tags_h;
    logic     [NUM_REGS-1:0][TAG_W-1:0]   tags_l;

    reg_write_decode u_decode (
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_size(wr_size), .wr_data(wr_data),
        .tag_en(tag_en), .tag_addr(tag_addr), .tag_size(tag_size),
        .sec_load(sec_load), .sec_alloc(sec_alloc),
        .upper_in(upper_in), .high_in(high_in), .low_in(low_in)
    );

    gpr_bank #(.TAG_W(TAG_W)) u_bank (
        .clk(clk), .rst_n(rst_n), .sec_load(sec_load), .sec_alloc(sec_alloc),
        .upper_in(upper_in), .high_in(high_in), .low_in(low_in), .new_tag(new_tag),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .flush(flush),
        .regs(regs), .busy(busy), .tags_u(tags_u), .tags_h(tags_h), .tags_l(tags_l)
    );

    gpr_read_port #(.TAG_W(TAG_W)) u_read (
        .rd_addr(rd_addr), .rd_size(rd_size), .regs(regs), .busy(busy),
        .tags_u(tags_u), .tags_h(tags_h), .tags_l(tags_l),
        .rd_data(rd_data), .rd_busy(rd_busy),
        .rd_tag_u(rd_tag_u), .rd_tag_h(rd_tag_h), .rd_tag_l(rd_tag_l)
    );

endmodule

//--- verif/gpr_regfile_asserts.sv
`timescale 1ns/1ps

module gpr_regfile_asserts (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           tag_en,
    input logic                           flush,
    input gpr_arch_pkg::addr_t            rd_addr,
    input gpr_arch_pkg::size_e            rd_size,
    input logic [gpr_arch_pkg::REG_W-1:0] rd_data,
    input gpr_arch_pkg::sec_vec_t         rd_busy
);

    import gpr_arch_pkg::*;

    sec_vec_t covered;

    // sections the current read touches.
    assign covered = (rd_size == SZ_DWORD) ? 3'b111 :
                     (rd_size == SZ_WORD)  ? 3'b011 :
                     (rd_addr[2] ? 3'b010 : 3'b001);

    busy_in_cover: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_busy & ~covered) == 3'b000) else $error("rd_busy outside covered sections");

    flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
        (flush && !tag_en) |=> (rd_busy == 3'b000)) else $error("rd_busy set after flush");

    data_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(rd_data)) else $error("rd_data unknown");

endmodule

bind gpr_regfile_top gpr_regfile_asserts u_asserts (
    .clk(clk), .rst_n(rst_n), .tag_en(tag_en), .flush(flush), .rd_addr(rd_addr),
    .rd_size(rd_size), .rd_data(rd_data), .rd_busy(rd_busy)
);

//--- verif/tb_gpr_regfile.sv
`timescale 1ns/1ps

module tb_gpr_regfile;

    import gpr_arch_pkg::*;

    localparam int TAG_W = 7;

    // cycles per phase, reset included.
    localparam int RESET_CYCLES  = 4;
    localparam int STATE_CYCLES  = 24;
    localparam int WRITE_CYCLES  = 24 * 25;
    localparam int ALLOC_CYCLES  = 16;
    localparam int FLUSH_CYCLES  = 12;
    localparam int RANDOM_CYCLES = 200;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + STATE_CYCLES + WRITE_CYCLES +
                                   ALLOC_CYCLES + FLUSH_CYCLES + RANDOM_CYCLES;
    localparam int TIMEOUT_NS    = TOTAL_CYCLES * 40 + 4000;

    logic clk;
    logic rst_n;
    logic wr_en;
    addr_t wr_addr;
    size_e wr_size;
    logic [31:0] wr_data;
    logic tag_en;
    addr_t tag_addr;
    size_e tag_size;
    logic [TAG_W-1:0] new_tag;
    logic cdb_valid;
    logic [TAG_W-1:0] cdb_tag;
    logic flush;
    addr_t rd_addr;
    size_e rd_size;
    logic [31:0] rd_data;
    sec_vec_t rd_busy;
    logic [TAG_W-1:0] rd_tag_u;
    logic [TAG_W-1:0] rd_tag_h;
    logic [TAG_W-1:0] rd_tag_l;

    // operation for the next cycle.
    logic op_wr;
    addr_t op_waddr;
    size_e op_wsize;
    logic [31:0] op_wdata;
    logic op_tag;
    addr_t op_taddr;
    size_e op_tsize;
    logic [TAG_W-1:0] op_ntag;
    logic op_cdb;
    logic [TAG_W-1:0] op_ctag;
    logic op_flush;
    addr_t op_raddr;
    size_e op_rsize;

    // reference model with section index 0 low, 1 high, 2 upper.
    logic [31:0] m_reg [8];
    logic [2:0] m_busy [8];
    logic [TAG_W-1:0] m_tag [8][3];

    logic [31:0] lfsr_state;

    gpr_regfile_top #(.TAG_W(TAG_W)) dut (
        .clk(clk), .rst_n(rst_n), .wr_en(wr_en), .wr_addr(wr_addr), .wr_size(wr_size),
        .wr_data(wr_data), .tag_en(tag_en), .tag_addr(tag_addr), .tag_size(tag_size),
        .new_tag(new_tag), .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .flush(flush),
        .rd_addr(rd_addr), .rd_size(rd_size), .rd_data(rd_data), .rd_busy(rd_busy),
        .rd_tag_u(rd_tag_u), .rd_tag_h(rd_tag_h), .rd_tag_l(rd_tag_l)
    );

    always #20 clk = ~clk;

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic size_e to_size(input logic [1:0] b);
        if (b == 2'd0) return SZ_BYTE;
        if (b == 2'd1) return SZ_WORD;
        return SZ_DWORD;
    endfunction

    function automatic int reg_of(input addr_t a, input size_e s);
        if (s == SZ_BYTE && a >= 3'd4) return int'(a) - 4;
        return int'(a);
    endfunction

    function automatic logic [2:0] covers(input addr_t a, input size_e s);
        if (s == SZ_DWORD) return 3'b111;
        if (s == SZ_WORD) return 3'b011;
        if (a >= 3'd4) return 3'b010;
        return 3'b001;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_read();
        int r;
        logic [2:0] cv;
        logic [31:0] w;
        logic [31:0] exp;
        r  = reg_of(op_raddr, op_rsize);
        cv = covers(op_raddr, op_rsize);
        w  = m_reg[r];
        if (op_rsize == SZ_DWORD) exp = w;
        else if (op_rsize == SZ_WORD) exp = {{16{w[15]}}, w[15:0]};
        else if (cv[1]) exp = {{24{w[15]}}, w[15:8]};
        else exp = {{24{w[7]}}, w[7:0]};
        check(rd_data, exp, "rd_data");
        check({29'b0, rd_busy}, {29'b0, m_busy[r] & cv}, "rd_busy");
        check({25'b0, rd_tag_u}, cv[2] ? {25'b0, m_tag[r][2]} : 32'b0, "rd_tag_u");
        check({25'b0, rd_tag_h}, cv[1] ? {25'b0, m_tag[r][1]} : 32'b0, "rd_tag_h");
        check({25'b0, rd_tag_l}, cv[0] ? {25'b0, m_tag[r][0]} : 32'b0, "rd_tag_l");
    endtask

    task automatic update_model();
        int r;
        logic [2:0] cv;
        logic [2:0] tcv;
        if (op_wr) begin
            r  = reg_of(op_waddr, op_wsize);
            cv = covers(op_waddr, op_wsize);
            if (cv[2]) m_reg[r][31:16] = op_wdata[31:16];
            if (cv[1]) m_reg[r][15:8] = (op_wsize == SZ_BYTE) ? op_wdata[7:0] : op_wdata[15:8];
            if (cv[0]) m_reg[r][7:0] = op_wdata[7:0];
        end
        tcv = covers(op_taddr, op_tsize);
        for (int i = 0; i < 8; i++) begin
            for (int k = 0; k < 3; k++) begin
                if (op_flush) begin
                    m_busy[i][k] = 1'b0;
                end else if (op_tag && reg_of(op_taddr, op_tsize) == i && tcv[k]) begin
                    m_busy[i][k] = 1'b1;
                    m_tag[i][k]  = op_ntag;
                end else if (op_cdb && m_tag[i][k] == op_ctag) begin
                    m_busy[i][k] = 1'b0;
                end
            end
        end
    endtask

    // drive one cycle, check the read at the falling edge.
    task automatic step();
        @(posedge clk);
        wr_en     <= op_wr;
        wr_addr   <= op_waddr;
        wr_size   <= op_wsize;
        wr_data   <= op_wdata;
        tag_en    <= op_tag;
        tag_addr  <= op_taddr;
        tag_size  <= op_tsize;
        new_tag   <= op_ntag;
        cdb_valid <= op_cdb;
        cdb_tag   <= op_ctag;
        flush     <= op_flush;
        rd_addr   <= op_raddr;
        rd_size   <= op_rsize;
        @(negedge clk);
        check_read();
        update_model();
        op_wr    = 1'b0;
        op_tag   = 1'b0;
        op_cdb   = 1'b0;
        op_flush = 1'b0;
    endtask

    task automatic read_at(input addr_t a, input size_e s);
        op_raddr = a;
        op_rsize = s;
        step();
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    task automatic test_reset_state();
        for (int s = 0; s < 3; s++) begin
            for (int a = 0; a < 8; a++) begin
                read_at(addr_t'(a), to_size(2'(s)));
                check(rd_data, 32'h0, "data after reset");
                check({29'b0, rd_busy}, 32'h0, "busy after reset");
            end
        end
    endtask

    task automatic test_sized_writes();
        logic [31:0] v;
        for (int s = 0; s < 3; s++) begin
            for (int a = 0; a < 8; a++) begin
                take_bits(32, v);
                op_wr    = 1'b1;
                op_waddr = addr_t'(a);
                op_wsize = to_size(2'(s));
                op_wdata = v;
                step();
                for (int rs = 0; rs < 3; rs++) begin
                    for (int ra = 0; ra < 8; ra++) begin
                        read_at(addr_t'(ra), to_size(2'(rs)));
                    end
                end
            end
        end
    endtask

    task automatic allocate(input addr_t a, input size_e s, input logic [TAG_W-1:0] t);
        op_tag   = 1'b1;
        op_taddr = a;
        op_tsize = s;
        op_ntag  = t;
    endtask

    task automatic test_alloc_complete();
        allocate(3'd1, SZ_WORD, 7'd5);
        step();
        allocate(3'd2, SZ_DWORD, 7'd5);
        step();
        allocate(3'd7, SZ_BYTE, 7'd9);
        step();
        read_at(3'd1, SZ_DWORD);
        check({29'b0, rd_busy}, 32'h3, "word allocate busy");
        check({25'b0, rd_tag_l}, 32'd5, "word allocate tag");
        op_cdb  = 1'b1;
        op_ctag = 7'd6;
        step();
        read_at(3'd2, SZ_DWORD);
        check({29'b0, rd_busy}, 32'h7, "busy after other tag");
        op_cdb  = 1'b1;
        op_ctag = 7'd5;
        step();
        for (int a = 0; a < 8; a++) begin
            read_at(addr_t'(a), SZ_DWORD);
        end
        read_at(3'd3, SZ_DWORD);
        check({29'b0, rd_busy}, 32'h2, "bh still pending");
    endtask

    task automatic test_priority_flush();
        allocate(3'd0, SZ_WORD, 7'd12);
        step();
        allocate(3'd0, SZ_WORD, 7'd13);
        op_cdb  = 1'b1;
        op_ctag = 7'd12;
        step();
        read_at(3'd0, SZ_WORD);
        check({29'b0, rd_busy}, 32'h3, "allocate over completion");
        check({25'b0, rd_tag_l}, 32'd13, "new tag kept");
        op_flush = 1'b1;
        step();
        for (int a = 0; a < 8; a++) begin
            read_at(addr_t'(a), SZ_DWORD);
            check({29'b0, rd_busy}, 32'h0, "busy after flush");
        end
    endtask

    task automatic test_random_mix();
        logic [31:0] v;
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            take_bits(1, v);
            op_wr = v[0];
            take_bits(3, v);
            op_waddr = addr_t'(v[2:0]);
            take_bits(2, v);
            op_wsize = to_size(v[1:0]);
            take_bits(32, op_wdata);
            take_bits(1, v);
            op_tag = v[0];
            take_bits(3, v);
            op_taddr = addr_t'(v[2:0]);
            take_bits(2, v);
            op_tsize = to_size(v[1:0]);
            take_bits(3, v);
            op_ntag = {4'b0, v[2:0]};
            take_bits(1, v);
            op_cdb = v[0];
            take_bits(3, v);
            op_ctag = {4'b0, v[2:0]};
            take_bits(4, v);
            op_flush = &v[3:0];
            take_bits(3, v);
            op_raddr = addr_t'(v[2:0]);
            take_bits(2, v);
            op_rsize = to_size(v[1:0]);
            step();
        end
    endtask

    // ----------------------------------------
    // main sequence and watchdog
    // ----------------------------------------
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the tests did not finish in time");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_size = SZ_BYTE;
        wr_data = '0;
        tag_en = 1'b0;
        tag_addr = '0;
        tag_size = SZ_BYTE;
        new_tag = '0;
        cdb_valid = 1'b0;
        cdb_tag = '0;
        flush = 1'b0;
        rd_addr = '0;
        rd_size = SZ_BYTE;
        op_wr = 1'b0;
        op_waddr = '0;
        op_wsize = SZ_BYTE;
        op_wdata = '0;
        op_tag = 1'b0;
        op_taddr = '0;
        op_tsize = SZ_BYTE;
        op_ntag = '0;
        op_cdb = 1'b0;
        op_ctag = '0;
        op_flush = 1'b0;
        op_raddr = '0;
        op_rsize = SZ_BYTE;
        lfsr_state = 32'h7979f1d9;
        for (int i = 0; i < 8; i++) begin
            m_reg[i] = '0;
            m_busy[i] = '0;
            for (int k = 0; k < 3; k++) m_tag[i][k] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_state();
        test_sized_writes();
        test_alloc_complete();
        test_priority_flush();
        test_random_mix();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- build.f
src/gpr_arch_pkg.sv
src/gpr_tag_pkg.sv
src/gpr_section.sv
src/reg_write_decode.sv
src/gpr_bank.sv
src/gpr_read_port.sv
src/gpr_regfile_top.sv
verif/gpr_regfile_asserts.sv
verif/tb_gpr_regfile.sv

//--- Makefile
VERILATOR = verilator
TOP       = tb_gpr_regfile
FILELIST  = build.f
OBJ_DIR   = obj_dir
VFLAGS    = --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
